/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int unsigned XLEN = 32;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [3:0]      byte_sel_t;

    // --------------------------------------------------
    // csr addresses and bit positions
    // --------------------------------------------------
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;

    // global interrupt enable in mstatus
    localparam int unsigned MSTATUS_MIE_BIT = 3;
    // per-source enables in mie
    localparam int unsigned MIE_MSIE_BIT = 3;
    localparam int unsigned MIE_MTIE_BIT = 7;
    localparam int unsigned MIE_MEIE_BIT = 11;

    // --------------------------------------------------
    // enums
    // --------------------------------------------------
    typedef enum logic [3:0] {
        MEM_OP_NONE = 4'd0,
        MEM_OP_LB   = 4'd1,
        MEM_OP_LBU  = 4'd2,
        MEM_OP_LH   = 4'd3,
        MEM_OP_LHU  = 4'd4,
        MEM_OP_LW   = 4'd5,
        MEM_OP_SB   = 4'd6,
        MEM_OP_SH   = 4'd7,
        MEM_OP_SW   = 4'd8
    } mem_op_e;

    // cause codes as seen by the trap handler
    typedef enum logic [3:0] {
        EXT_INT        = 4'd0,
        ECALL          = 4'd1,
        TRAP           = 4'd2,
        TIMER          = 4'd3,
        ILLEGAL        = 4'd4,
        LOAD_MISALIGN  = 4'd5,
        STORE_MISALIGN = 4'd6,
        OVERFLOW       = 4'd7,
        MRET           = 4'd15
    } trap_cause_e;

    // --------------------------------------------------
    // grouped signals
    // --------------------------------------------------
    // events raised by the instruction itself
    typedef struct packed {
        logic ecall;
        logic illegal;
        logic trap;
        logic overflow;
        logic mret;
    } except_flags_t;

    typedef struct packed {
        logic        valid;
        trap_cause_e cause;
    } trap_t;

    // request on the data bus
    typedef struct packed {
        logic      ce;
        logic      we;
        byte_sel_t sel;
        data_t     addr;
        data_t     wdata;
    } mem_req_t;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        data_t     data;
    } csr_wr_t;

    // committed or forwarded csr values
    typedef struct packed {
        data_t mstatus;
        data_t mie;
        data_t mepc;
        data_t mtvec;
    } csr_view_t;

    // payload handed to writeback
    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        data_t     result;
        csr_wr_t   csr;
    } wb_t;

endpackage

`default_nettype wire

/* design/load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module load_align (
    input  mem_pkg::mem_op_e op_i,
    input  logic [1:0]       offset_i,
    input  mem_pkg::data_t   load_data_i,
    output mem_pkg::data_t   data_o,
    output logic             misaligned_o
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // byte lanes run big end first, offset 0 is bits 31:24
    always_comb begin
        case (offset_i)
            2'd0:    lane_byte = load_data_i[31:24];
            2'd1:    lane_byte = load_data_i[23:16];
            2'd2:    lane_byte = load_data_i[15:8];
            default: lane_byte = load_data_i[7:0];
        endcase
    end

    // upper half at offset 0, lower half at offset 2
    assign lane_half = offset_i[1] ? load_data_i[15:0] : load_data_i[31:16];

    always_comb begin
        data_o       = '0;
        misaligned_o = 1'b0;
        case (op_i)
            mem_pkg::MEM_OP_LB: begin
                data_o = {{24{lane_byte[7]}}, lane_byte};
            end
            mem_pkg::MEM_OP_LBU: begin
                data_o = {24'd0, lane_byte};
            end
            mem_pkg::MEM_OP_LH, mem_pkg::MEM_OP_LHU: begin
                // odd offset cannot hold a halfword
                if (offset_i[0]) begin
                    misaligned_o = 1'b1;
                end else if (op_i == mem_pkg::MEM_OP_LH) begin
                    data_o = {{16{lane_half[15]}}, lane_half};
                end else begin
                    data_o = {16'd0, lane_half};
                end
            end
            mem_pkg::MEM_OP_LW: begin
                if (offset_i != 2'd0) begin
                    misaligned_o = 1'b1;
                end else begin
                    data_o = load_data_i;
                end
            end
            // stores and no-op return nothing
            default: begin
                data_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/store_align.sv */
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  mem_pkg::mem_op_e  op_i,
    input  logic [1:0]        offset_i,
    input  mem_pkg::data_t    store_data_i,
    output mem_pkg::data_t    data_o,
    output mem_pkg::byte_sel_t sel_o,
    output logic              misaligned_o
);

    logic size_bad;
    logic is_store;

    // select follows access size, loads included
    always_comb begin
        sel_o    = 4'b0000;
        size_bad = 1'b0;
        case (op_i)
            mem_pkg::MEM_OP_LB, mem_pkg::MEM_OP_LBU, mem_pkg::MEM_OP_SB: begin
                // offset 0 marks bit 0, offset 3 marks bit 3
                sel_o = 4'b0001 << offset_i;
            end
            mem_pkg::MEM_OP_LH, mem_pkg::MEM_OP_LHU, mem_pkg::MEM_OP_SH: begin
                case (offset_i)
                    2'd0:    sel_o = 4'b0011;
                    2'd2:    sel_o = 4'b1100;
                    default: size_bad = 1'b1;
                endcase
            end
            mem_pkg::MEM_OP_LW, mem_pkg::MEM_OP_SW: begin
                if (offset_i == 2'd0) begin
                    sel_o = 4'b1111;
                end else begin
                    size_bad = 1'b1;
                end
            end
            default: begin
                sel_o = 4'b0000;
            end
        endcase
    end

    // replicate so any selected lane sees the value
    always_comb begin
        case (op_i)
            mem_pkg::MEM_OP_SB: data_o = {4{store_data_i[7:0]}};
            mem_pkg::MEM_OP_SH: data_o = {2{store_data_i[15:0]}};
            mem_pkg::MEM_OP_SW: data_o = store_data_i;
            default:            data_o = '0;
        endcase
    end

    assign is_store = (op_i == mem_pkg::MEM_OP_SB) || (op_i == mem_pkg::MEM_OP_SH) ||
                      (op_i == mem_pkg::MEM_OP_SW);

    // load misalignment is flagged by load_align
    assign misaligned_o = is_store && size_bad;

endmodule

`default_nettype wire

/* design/csr_bypass.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_bypass (
    input  mem_pkg::csr_wr_t   wb_csr_i,
    input  mem_pkg::csr_view_t csr_i,
    output mem_pkg::csr_view_t csr_o
);

    logic hit_mstatus;
    logic hit_mie;
    logic hit_mepc;
    logic hit_mtvec;

    // --------------------------------------------------
    // address match against the write now in writeback
    // --------------------------------------------------
    assign hit_mstatus = wb_csr_i.we && (wb_csr_i.addr == mem_pkg::CSR_MSTATUS);
    assign hit_mie     = wb_csr_i.we && (wb_csr_i.addr == mem_pkg::CSR_MIE);
    assign hit_mepc    = wb_csr_i.we && (wb_csr_i.addr == mem_pkg::CSR_MEPC);
    assign hit_mtvec   = wb_csr_i.we && (wb_csr_i.addr == mem_pkg::CSR_MTVEC);

    // --------------------------------------------------
    // forward over committed values
    // --------------------------------------------------
    // newer writeback data wins
    assign csr_o.mstatus = hit_mstatus ? wb_csr_i.data : csr_i.mstatus;
    assign csr_o.mie     = hit_mie     ? wb_csr_i.data : csr_i.mie;
    // mepc and mtvec feed the hazard unit
    assign csr_o.mepc    = hit_mepc    ? wb_csr_i.data : csr_i.mepc;
    assign csr_o.mtvec   = hit_mtvec   ? wb_csr_i.data : csr_i.mtvec;

endmodule

`default_nettype wire

/* design/trap_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module trap_arbiter (
    input  mem_pkg::csr_view_t     csr_i,
    input  mem_pkg::data_t         inst_addr_i,
    input  mem_pkg::except_flags_t flags_i,
    input  logic                   load_misaligned_i,
    input  logic                   store_misaligned_i,
    input  logic                   ext_int_i,
    input  logic                   timer_i,
    output mem_pkg::trap_t         trap_o
);

    logic gate_open;
    logic msie;
    logic mtie;
    logic meie;

    // --------------------------------------------------
    // enables
    // --------------------------------------------------
    // zero address means no real instruction has arrived yet
    assign gate_open = csr_i.mstatus[mem_pkg::MSTATUS_MIE_BIT] && (inst_addr_i != '0);

    assign msie = csr_i.mie[mem_pkg::MIE_MSIE_BIT];
    assign mtie = csr_i.mie[mem_pkg::MIE_MTIE_BIT];
    assign meie = csr_i.mie[mem_pkg::MIE_MEIE_BIT];

    // --------------------------------------------------
    // fixed priority pick
    // --------------------------------------------------
    always_comb begin
        trap_o.valid = 1'b0;
        trap_o.cause = mem_pkg::EXT_INT;
        if (gate_open) begin
            trap_o.valid = 1'b1;
            // interrupts first, each masked by its mie bit
            if (ext_int_i && meie) begin
                trap_o.cause = mem_pkg::EXT_INT;
            end else if (flags_i.ecall && msie) begin
                trap_o.cause = mem_pkg::ECALL;
            end else if (flags_i.trap && msie) begin
                trap_o.cause = mem_pkg::TRAP;
            end else if (timer_i && mtie) begin
                trap_o.cause = mem_pkg::TIMER;
            // synchronous exceptions are not maskable
            end else if (flags_i.illegal) begin
                trap_o.cause = mem_pkg::ILLEGAL;
            end else if (load_misaligned_i) begin
                trap_o.cause = mem_pkg::LOAD_MISALIGN;
            end else if (store_misaligned_i) begin
                trap_o.cause = mem_pkg::STORE_MISALIGN;
            end else if (flags_i.overflow) begin
                trap_o.cause = mem_pkg::OVERFLOW;
            end else if (flags_i.mret) begin
                trap_o.cause = mem_pkg::MRET;
            end else begin
                // nothing pending
                trap_o.valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  mem_pkg::mem_op_e       op_i,
    input  mem_pkg::data_t         addr_i,
    input  mem_pkg::data_t         store_data_i,
    input  mem_pkg::data_t         load_data_i,
    input  mem_pkg::reg_addr_t     wd_i,
    input  logic                   wreg_i,
    input  mem_pkg::data_t         result_i,
    input  mem_pkg::csr_wr_t       csr_wr_i,
    input  mem_pkg::csr_wr_t       wb_csr_i,
    input  mem_pkg::csr_view_t     csr_i,
    input  mem_pkg::except_flags_t flags_i,
    input  mem_pkg::data_t         inst_addr_i,
    input  logic                   ext_int_i,
    input  logic                   timer_i,
    output mem_pkg::mem_req_t      mem_req_o,
    output mem_pkg::trap_t         trap_o,
    output mem_pkg::data_t         mepc_o,
    output mem_pkg::data_t         mtvec_o,
    output mem_pkg::wb_t           wb_o
);

    logic                 is_load;
    logic                 is_store;
    mem_pkg::data_t       ld_data;
    logic                 ld_misaligned;
    mem_pkg::data_t       st_data;
    mem_pkg::byte_sel_t   st_sel;
    logic                 st_misaligned;
    mem_pkg::csr_view_t   csr_fwd;
    mem_pkg::wb_t         wb_d;

    // --------------------------------------------------
    // op decode
    // --------------------------------------------------
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (op_i)
            mem_pkg::MEM_OP_LB, mem_pkg::MEM_OP_LBU, mem_pkg::MEM_OP_LH,
            mem_pkg::MEM_OP_LHU, mem_pkg::MEM_OP_LW: is_load  = 1'b1;
            mem_pkg::MEM_OP_SB, mem_pkg::MEM_OP_SH,
            mem_pkg::MEM_OP_SW:                      is_store = 1'b1;
            default:                                 is_load  = 1'b0;
        endcase
    end

    load_align i_load_align (
        .op_i         (op_i),
        .offset_i     (addr_i[1:0]),
        .load_data_i  (load_data_i),
        .data_o       (ld_data),
        .misaligned_o (ld_misaligned)
    );

    store_align i_store_align (
        .op_i         (op_i),
        .offset_i     (addr_i[1:0]),
        .store_data_i (store_data_i),
        .data_o       (st_data),
        .sel_o        (st_sel),
        .misaligned_o (st_misaligned)
    );

    csr_bypass i_csr_bypass (
        .wb_csr_i (wb_csr_i),
        .csr_i    (csr_i),
        .csr_o    (csr_fwd)
    );

    trap_arbiter i_trap_arbiter (
        .csr_i              (csr_fwd),
        .inst_addr_i        (inst_addr_i),
        .flags_i            (flags_i),
        .load_misaligned_i  (ld_misaligned),
        .store_misaligned_i (st_misaligned),
        .ext_int_i          (ext_int_i),
        .timer_i            (timer_i),
        .trap_o             (trap_o)
    );

    // --------------------------------------------------
    // data bus request
    // --------------------------------------------------
    assign mem_req_o.ce    = is_load || is_store;
    // any taken trap kills the write
    assign mem_req_o.we    = is_store && !trap_o.valid;
    // sel and wdata are already zero for no-op
    assign mem_req_o.sel   = st_sel;
    assign mem_req_o.addr  = addr_i;
    assign mem_req_o.wdata = st_data;

    // forwarded values for the hazard unit
    assign mepc_o  = csr_fwd.mepc;
    assign mtvec_o = csr_fwd.mtvec;

    // --------------------------------------------------
    // writeback register
    // --------------------------------------------------
    assign wb_d.wreg   = wreg_i;
    assign wb_d.wd     = wd_i;
    // loads return memory data, stores return nothing
    assign wb_d.result = is_load  ? ld_data :
                         is_store ? '0      : result_i;
    assign wb_d.csr    = csr_wr_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= wb_d;
        end
    end

endmodule

`default_nettype wire

/* verification/mem_stage_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_sva (
    input logic              clk,
    input logic              arst_n_i,
    input mem_pkg::mem_req_t mem_req_o,
    input mem_pkg::trap_t    trap_o,
    input mem_pkg::wb_t      wb_o
);

    // --------------------------------------------------
    // bus request
    // --------------------------------------------------
    // a write is always an enabled access
    we_implies_ce: assert property (@(posedge clk) mem_req_o.we |-> mem_req_o.ce)
        else $error("mem_req_o.we set without mem_req_o.ce");

    // taken trap kills the store
    no_we_on_trap: assert property (@(posedge clk) !(mem_req_o.we && trap_o.valid))
        else $error("mem_req_o.we set while trap_o.valid");

    // --------------------------------------------------
    // writeback register under reset
    // --------------------------------------------------
    wb_quiet_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> (!wb_o.wreg && !wb_o.csr.we))
        else $error("wb_o write enable set during reset");

endmodule

bind mem_stage mem_stage_sva i_sva (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .mem_req_o (mem_req_o),
    .trap_o    (trap_o),
    .wb_o      (wb_o)
);

`default_nettype wire

/* verification/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    // one table row, inputs first then expected values
    typedef struct packed {
        mem_pkg::mem_op_e       op;
        logic [1:0]             off;
        // committed mstatus.MIE
        logic                   gie;
        // committed meie, mtie, msie
        logic [2:0]             ien;
        mem_pkg::csr_wr_t       wbc;
        mem_pkg::except_flags_t flg;
        // ext, timer
        logic [1:0]             irq;
        // nonzero instruction address
        logic                   run;
        mem_pkg::byte_sel_t     sel;
        mem_pkg::trap_t         trap;
    } row_t;

    logic                   clk;
    logic                   arst_n_i;
    mem_pkg::mem_op_e       op_i;
    mem_pkg::data_t         addr_i;
    mem_pkg::data_t         store_data_i;
    mem_pkg::data_t         load_data_i;
    mem_pkg::reg_addr_t     wd_i;
    logic                   wreg_i;
    mem_pkg::data_t         result_i;
    mem_pkg::csr_wr_t       csr_wr_i;
    mem_pkg::csr_wr_t       wb_csr_i;
    mem_pkg::csr_view_t     csr_i;
    mem_pkg::except_flags_t flags_i;
    mem_pkg::data_t         inst_addr_i;
    logic                   ext_int_i;
    logic                   timer_i;
    mem_pkg::mem_req_t      mem_req_o;
    mem_pkg::trap_t         trap_o;
    mem_pkg::data_t         mepc_o;
    mem_pkg::data_t         mtvec_o;
    mem_pkg::wb_t           wb_o;

    row_t             rows[$];
    mem_pkg::csr_wr_t no_wb;
    mem_pkg::trap_t   no_trap;
    int               errors;
    int               passed;
    int               failed;
    logic             timed_out;

    mem_stage i_dut (.*);

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [95:0] got, input logic [95:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    // poll at half-ns phase so edges are never sampled in their own step
    task automatic wait_rise();
        int   n;
        logic last;
        logic seen;
        n    = 0;
        last = clk;
        seen = 1'b0;
        while (!seen && n < 400) begin
            #1;
            n++;
            seen = (clk === 1'b1) && (last === 1'b0);
            last = clk;
        end
        if (!seen) begin
            $display("timeout: no rising clock edge within %0d ns", n);
            timed_out = 1'b1;
        end
    endtask

    // offset 0 is the top byte, offset 2 the low halfword
    function automatic mem_pkg::data_t load_model(input mem_pkg::mem_op_e op,
                                                  input logic [1:0] off,
                                                  input mem_pkg::data_t d);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(d >> (5'd24 - {off, 3'b000}));
        h = off[1] ? d[15:0] : d[31:16];
        case (op)
            mem_pkg::MEM_OP_LB:  return {{24{b[7]}}, b};
            mem_pkg::MEM_OP_LBU: return {24'd0, b};
            mem_pkg::MEM_OP_LH:  return off[0] ? 32'd0 : {{16{h[15]}}, h};
            mem_pkg::MEM_OP_LHU: return off[0] ? 32'd0 : {16'd0, h};
            mem_pkg::MEM_OP_LW:  return (off == 2'd0) ? d : 32'd0;
            default:             return 32'd0;
        endcase
    endfunction

    // store data lands in every lane
    function automatic mem_pkg::data_t store_model(input mem_pkg::mem_op_e op,
                                                   input mem_pkg::data_t d);
        case (op)
            mem_pkg::MEM_OP_SB: return {4{d[7:0]}};
            mem_pkg::MEM_OP_SH: return {2{d[15:0]}};
            mem_pkg::MEM_OP_SW: return d;
            default:            return 32'd0;
        endcase
    endfunction

    task automatic run_row(input int idx);
        row_t             r;
        int               errs_before;
        logic             is_store;
        mem_pkg::data_t   st;
        mem_pkg::data_t   ld;
        mem_pkg::data_t   res;
        mem_pkg::data_t   exp_mepc;
        mem_pkg::data_t   exp_mtvec;
        mem_pkg::csr_wr_t own_csr;
        mem_pkg::wb_t     exp_wb;
        r           = rows[idx];
        errs_before = errors;
        st          = $urandom();
        // top bit of every lane set so sign and zero extension differ
        ld          = $urandom() | 32'h8080_8080;
        res         = $urandom();
        own_csr     = '{1'b1, 12'(idx), $urandom()};
        // drive the row
        op_i         = r.op;
        addr_i       = {30'h0000_1000, r.off};
        store_data_i = st;
        load_data_i  = ld;
        result_i     = res;
        wd_i         = 5'(idx);
        wreg_i       = 1'b1;
        csr_wr_i     = own_csr;
        wb_csr_i     = r.wbc;
        csr_i        = '0;
        csr_i.mstatus[mem_pkg::MSTATUS_MIE_BIT] = r.gie;
        csr_i.mie[mem_pkg::MIE_MEIE_BIT]        = r.ien[2];
        csr_i.mie[mem_pkg::MIE_MTIE_BIT]        = r.ien[1];
        csr_i.mie[mem_pkg::MIE_MSIE_BIT]        = r.ien[0];
        csr_i.mepc   = 32'h0000_1000;
        csr_i.mtvec  = 32'h0000_2000;
        flags_i      = r.flg;
        ext_int_i    = r.irq[1];
        timer_i      = r.irq[0];
        inst_addr_i  = r.run ? 32'h0000_0100 : 32'h0;
        #49.5;
        // ---------------------------------------------
        // same-cycle outputs
        // ---------------------------------------------
        is_store  = r.op inside {mem_pkg::MEM_OP_SB, mem_pkg::MEM_OP_SH, mem_pkg::MEM_OP_SW};
        exp_mepc  = (r.wbc.we && r.wbc.addr == mem_pkg::CSR_MEPC) ? r.wbc.data : 32'h0000_1000;
        exp_mtvec = (r.wbc.we && r.wbc.addr == mem_pkg::CSR_MTVEC) ? r.wbc.data : 32'h0000_2000;
        check("mem_req_o.ce", 96'(mem_req_o.ce), 96'(r.op != mem_pkg::MEM_OP_NONE));
        check("mem_req_o.we", 96'(mem_req_o.we), 96'(is_store && !r.trap.valid));
        check("mem_req_o.sel", 96'(mem_req_o.sel), 96'(r.sel));
        check("mem_req_o.addr", 96'(mem_req_o.addr), 96'({30'h0000_1000, r.off}));
        check("mem_req_o.wdata", 96'(mem_req_o.wdata), 96'(store_model(r.op, st)));
        check("trap_o.valid", 96'(trap_o.valid), 96'(r.trap.valid));
        // cause only means something on a valid trap
        if (r.trap.valid) begin
            check("trap_o.cause", 96'(trap_o.cause), 96'(r.trap.cause));
        end
        check("mepc_o", 96'(mepc_o), 96'(exp_mepc));
        check("mtvec_o", 96'(mtvec_o), 96'(exp_mtvec));
        // writeback one cycle later
        wait_rise();
        exp_wb = '{1'b1, 5'(idx),
                   (r.op == mem_pkg::MEM_OP_NONE) ? res : load_model(r.op, r.off, ld), own_csr};
        if (!timed_out) begin
            check("wb_o", 96'(wb_o), 96'(exp_wb));
        end
        #0.5;
        if (errors == errs_before && !timed_out) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d %s: %s", idx, r.op.name(),
                 (errors == errs_before && !timed_out) ? "pass" : "fail");
    endtask

    initial begin
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        op_i         = mem_pkg::MEM_OP_NONE;
        addr_i       = '0;
        store_data_i = '0;
        load_data_i  = '0;
        wd_i         = '0;
        wreg_i       = 1'b0;
        result_i     = '0;
        csr_wr_i     = '0;
        wb_csr_i     = '0;
        csr_i        = '0;
        flags_i      = '0;
        inst_addr_i  = '0;
        ext_int_i    = 1'b0;
        timer_i      = 1'b0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        timed_out    = 1'b0;
        no_wb        = '0;
        no_trap      = '0;
        void'($urandom(32'h37ac_1858));

        // --------------------------------------------------
        // table: op, off, gie, ien, wb csr, flags, irq, run | sel, trap
        // --------------------------------------------------
        // loads at each legal offset
        rows.push_back('{mem_pkg::MEM_OP_LB, 2'd0, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b0001, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_LB, 2'd1, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b0010, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_LBU, 2'd2, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b0100, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_LBU, 2'd3, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b1000, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_LH, 2'd0, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b0011, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_LHU, 2'd2, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b1100, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_LW, 2'd0, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b1111, no_trap});
        // stores
        rows.push_back('{mem_pkg::MEM_OP_SB, 2'd3, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b1000, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_SH, 2'd0, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b0011, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_SW, 2'd0, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b1111, no_trap});
        // misaligned, beating overflow and mret
        rows.push_back('{mem_pkg::MEM_OP_LH, 2'd1, 1'b1, 3'b000, no_wb, 5'b00010, 2'b00, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::LOAD_MISALIGN}});
        rows.push_back('{mem_pkg::MEM_OP_SH, 2'd3, 1'b1, 3'b000, no_wb, 5'b00000, 2'b00, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::STORE_MISALIGN}});
        rows.push_back('{mem_pkg::MEM_OP_SW, 2'd1, 1'b1, 3'b000, no_wb, 5'b00011, 2'b00, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::STORE_MISALIGN}});
        // csr forwarding from writeback
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b000,
                         '{1'b1, mem_pkg::CSR_MEPC, 32'h0000_3000}, 5'b00000, 2'b00, 1'b1,
                         4'b0000, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b000,
                         '{1'b1, mem_pkg::CSR_MTVEC, 32'h0000_5000}, 5'b00000, 2'b00, 1'b1,
                         4'b0000, no_trap});
        // forwarded mstatus opens the gate
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b0, 3'b001,
                         '{1'b1, mem_pkg::CSR_MSTATUS, 32'h0000_0008}, 5'b00100, 2'b00, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::TRAP}});
        // forwarded mie sets msie
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b000,
                         '{1'b1, mem_pkg::CSR_MIE, 32'h0000_0008}, 5'b10000, 2'b00, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::ECALL}});
        // priority walk
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b111, no_wb, 5'b11111, 2'b11, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::EXT_INT}});
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b011, no_wb, 5'b10100, 2'b11, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::ECALL}});
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b111, no_wb, 5'b01000, 2'b01, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::TIMER}});
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b101, no_wb, 5'b01011, 2'b01, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::ILLEGAL}});
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b111, no_wb, 5'b00011, 2'b00, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::OVERFLOW}});
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b111, no_wb, 5'b00001, 2'b00, 1'b1,
                         4'b0000, '{1'b1, mem_pkg::MRET}});
        // masked or gated off
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b110, no_wb, 5'b10000, 2'b00, 1'b1,
                         4'b0000, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b0, 3'b111, no_wb, 5'b11111, 2'b11, 1'b1,
                         4'b0000, no_trap});
        rows.push_back('{mem_pkg::MEM_OP_NONE, 2'd0, 1'b1, 3'b111, no_wb, 5'b11111, 2'b11, 1'b0,
                         4'b0000, no_trap});
        // trap cancels an aligned store
        rows.push_back('{mem_pkg::MEM_OP_SW, 2'd0, 1'b1, 3'b000, no_wb, 5'b01000, 2'b00, 1'b1,
                         4'b1111, '{1'b1, mem_pkg::ILLEGAL}});

        // --------------------------------------------------
        // reset, then the table
        // --------------------------------------------------
        #0.5;
        for (int c = 0; c < 16 && !timed_out; c++) begin
            wait_rise();
        end
        if (!timed_out) begin
            check("wb_o", 96'(wb_o), 96'(0));
            if (errors == 0) begin
                passed++;
            end else begin
                failed++;
            end
            $display("test reset: %s", (errors == 0) ? "pass" : "fail");
        end
        #0.5;
        arst_n_i = 1'b1;
        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            run_row(i);
        end

        $display("%0d passed, %0d failed, %0d mismatches", passed, failed, errors);
        if (errors == 0 && failed == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
design/mem_pkg.sv
design/load_align.sv
design/store_align.sv
design/csr_bypass.sv
design/trap_arbiter.sv
design/mem_stage.sv
verification/mem_stage_sva.sv
verification/tb_mem_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mem_stage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP), fails unless the run passes"
	@echo "  clean  remove $(BUILD_DIR)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(BUILD_DIR)
